// File: Makefile
VERILATOR  ?= verilator
FILELIST   ?= filelist.f
TB_TOP     ?= tb_soc_mem_subsystem
RTL_TOP    ?= soc_mem_subsystem
BUILD_DIR  ?= obj_dir
INC_DIR    ?= include
LINT_FLAGS ?= --lint-only
SIM_FLAGS  ?= --binary --timing -j 0
PASS_MSG   ?= NO ERRORS

RTL_FILES := $(filter rtl/%,$(shell cat $(FILELIST)))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) +incdir+$(INC_DIR) --top-module $(RTL_TOP) $(RTL_FILES)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: filelist.f
+incdir+include
rtl/mem_bus_pkg.sv
rtl/soc_map_pkg.sv
rtl/mem_req_if.sv
rtl/region_decoder.sv
rtl/boot_rom.sv
rtl/l2_spm.sv
rtl/rsp_merge.sv
rtl/soc_mem_subsystem.sv
tests/rsp_checker.sv
tests/tb_soc_mem_subsystem.sv

// File: include/boot_image.svh
// First-stage boot code, one 64-bit word per entry
localparam mem_bus_pkg::data_t BootImage [soc_map_pkg::RomWords] = '{
  64'h0000_0517_0000_0297, 64'h0405_0513_0102_8293,
  64'hF140_2573_3420_2F73, 64'h0205_1063_0000_0613,
  64'h1C00_05B7_0005_8593, 64'h0000_0693_0080_0713,
  64'h00B6_3023_0086_8693, 64'hFEE6_9CE3_0000_0013,
  64'h1050_0073_FFDF_F06F, 64'h0000_0013_0000_0013,
  64'h3000_2073_3040_1073, 64'h0800_0793_3007_A073,
  64'h1C00_0137_0001_0113, 64'h0000_0193_0000_0213,
  64'h0005_8067_0000_0013, 64'hDEAD_BEEF_CAFE_F00D,
  64'h0123_4567_89AB_CDEF, 64'hFEDC_BA98_7654_3210,
  64'h5555_AAAA_5555_AAAA, 64'hA5A5_5A5A_0F0F_F0F0,
  64'h0000_0001_0000_0002, 64'h0000_0004_0000_0008,
  64'h1111_2222_3333_4444, 64'h5555_6666_7777_8888,
  64'h9999_AAAA_BBBB_CCCC, 64'hDDDD_EEEE_FFFF_0000,
  64'h7F45_4C46_0201_0100, 64'h0002_00F3_0000_0001,
  64'h0000_0000_8000_0000, 64'h0000_0040_0000_0000,
  64'h1C00_0000_0000_2000, 64'hB007_C0DE_600D_F00D
};

// File: rtl/boot_rom.sv
`timescale 1ns/1ps
`default_nettype none

module boot_rom (
  input  wire logic         clk_i,
  input  wire logic         ndmreset_n,
  mem_req_if.target         req_i,
  output logic              rsp_valid_o,
  output mem_bus_pkg::rsp_t rsp_o
);

  `include "boot_image.svh"

  logic [soc_map_pkg::RomIdxWidth-1:0] rom_idx;

  // Region is smaller than the shared index
  assign rom_idx = req_i.word_idx[soc_map_pkg::RomIdxWidth-1:0];

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rsp_valid_o <= 1'b0;
      rsp_o       <= '0;
    end else begin
      rsp_valid_o <= req_i.req;
      if (req_i.req) begin
        if (req_i.we) begin
          // Read-only region
          rsp_o.rdata <= '0;
          rsp_o.err   <= 1'b1;
        end else begin
          rsp_o.rdata <= BootImage[rom_idx];
          rsp_o.err   <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/l2_spm.sv
`timescale 1ns/1ps
`default_nettype none

module l2_spm (
  input  wire logic         clk_i,
  input  wire logic         ndmreset_n,
  mem_req_if.target         req_i,
  output logic              rsp_valid_o,
  output mem_bus_pkg::rsp_t rsp_o
);

  mem_bus_pkg::data_t mem_q [soc_map_pkg::SpmWords];

  // --------------------
  // Storage
  // --------------------
  always_ff @(posedge clk_i) begin
    if (req_i.req && req_i.we) begin
      for (int unsigned b = 0; b < mem_bus_pkg::StrbWidth; b++) begin
        if (req_i.be[b]) begin
          mem_q[req_i.word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // --------------------
  // Response
  // --------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rsp_valid_o <= 1'b0;
      rsp_o       <= '0;
    end else begin
      rsp_valid_o <= req_i.req;
      if (req_i.req) begin
        rsp_o.err <= 1'b0;
        // Writes are acknowledged with zero data
        if (req_i.we) begin
          rsp_o.rdata <= '0;
        end else begin
          rsp_o.rdata <= mem_q[req_i.word_idx];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

  // --------------------
  // Bus widths
  // --------------------
  localparam int unsigned AddrWidth  = 32;
  localparam int unsigned DataWidth  = 64;
  localparam int unsigned StrbWidth  = DataWidth / 8;
  // Byte offset inside one data word
  localparam int unsigned WordOffset = $clog2(StrbWidth);

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  // --------------------
  // Response
  // --------------------
  typedef struct packed {
    data_t rdata;
    logic  err;
  } rsp_t;

endpackage

`default_nettype wire

// File: rtl/mem_req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_req_if;

  logic                   req;
  logic                   we;
  // Word index relative to the region base
  soc_map_pkg::word_idx_t word_idx;
  mem_bus_pkg::strb_t     be;
  mem_bus_pkg::data_t     wdata;

  // Decoder side
  modport initiator (
    output req,
    output we,
    output word_idx,
    output be,
    output wdata
  );

  // Memory side
  modport target (
    input req,
    input we,
    input word_idx,
    input be,
    input wdata
  );

endinterface

`default_nettype wire

// File: rtl/region_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module region_decoder (
  input  wire logic               clk_i,
  input  wire logic               ndmreset_n,
  input  wire logic               req_i,
  input  wire logic               we_i,
  input  wire mem_bus_pkg::addr_t addr_i,
  input  wire mem_bus_pkg::strb_t be_i,
  input  wire mem_bus_pkg::data_t wdata_i,
  mem_req_if.initiator            rom_o,
  mem_req_if.initiator            spm_o,
  output logic                    dec_err_o
);

  logic [soc_map_pkg::NumTargets-1:0] sel;
  mem_bus_pkg::addr_t                 rom_off;
  mem_bus_pkg::addr_t                 spm_off;

  // --------------------
  // Address match
  // --------------------
  // First rule that covers the address wins
  always_comb begin : p_match
    logic found;
    found = 1'b0;
    sel   = '0;
    for (int unsigned i = 0; i < soc_map_pkg::NumTargets; i++) begin
      if (!found && addr_i >= soc_map_pkg::AddrMap[i].start_addr &&
          addr_i < soc_map_pkg::AddrMap[i].end_addr) begin
        sel[soc_map_pkg::AddrMap[i].idx] = 1'b1;
        found = 1'b1;
      end
    end
  end

  assign rom_off = addr_i - soc_map_pkg::AddrMap[soc_map_pkg::TgtRom].start_addr;
  assign spm_off = addr_i - soc_map_pkg::AddrMap[soc_map_pkg::TgtSpm].start_addr;

  // --------------------
  // Steering
  // --------------------
  assign rom_o.req      = req_i & sel[soc_map_pkg::TgtRom];
  assign rom_o.we       = we_i;
  assign rom_o.word_idx = rom_off[mem_bus_pkg::WordOffset +: soc_map_pkg::SpmIdxWidth];
  assign rom_o.be       = be_i;
  assign rom_o.wdata    = wdata_i;

  assign spm_o.req      = req_i & sel[soc_map_pkg::TgtSpm];
  assign spm_o.we       = we_i;
  assign spm_o.word_idx = spm_off[mem_bus_pkg::WordOffset +: soc_map_pkg::SpmIdxWidth];
  assign spm_o.be       = be_i;
  assign spm_o.wdata    = wdata_i;

  // Unmapped access, answered one cycle later like the memories
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      dec_err_o <= 1'b0;
    end else begin
      dec_err_o <= req_i & ~(|sel);
    end
  end

endmodule

`default_nettype wire

// File: rtl/rsp_merge.sv
`timescale 1ns/1ps
`default_nettype none

module rsp_merge (
  input  wire logic               rom_valid_i,
  input  wire mem_bus_pkg::rsp_t  rom_rsp_i,
  input  wire logic               spm_valid_i,
  input  wire mem_bus_pkg::rsp_t  spm_rsp_i,
  input  wire logic               dec_err_i,
  output logic                    rsp_valid_o,
  output mem_bus_pkg::data_t      rsp_rdata_o,
  output logic                    rsp_err_o
);

  // Sources are mutually exclusive, so an AND-OR mux is enough
  assign rsp_valid_o = rom_valid_i | spm_valid_i | dec_err_i;

  assign rsp_rdata_o = ({mem_bus_pkg::DataWidth{rom_valid_i}} & rom_rsp_i.rdata) |
                       ({mem_bus_pkg::DataWidth{spm_valid_i}} & spm_rsp_i.rdata);

  // Decode error carries zero data
  assign rsp_err_o = (rom_valid_i & rom_rsp_i.err) |
                     (spm_valid_i & spm_rsp_i.err) |
                     dec_err_i;

endmodule

`default_nettype wire

// File: rtl/soc_map_pkg.sv
`default_nettype none

package soc_map_pkg;

  typedef enum logic [0:0] {
    TgtRom = 1'b0,
    TgtSpm = 1'b1
  } target_e;

  localparam int unsigned NumTargets = 2;

  // --------------------
  // Regions
  // --------------------
  localparam mem_bus_pkg::addr_t RomBase   = 32'h0001_0000;
  localparam mem_bus_pkg::addr_t RomLength = 32'h0000_0100;
  localparam mem_bus_pkg::addr_t SpmBase   = 32'h1C00_0000;
  localparam mem_bus_pkg::addr_t SpmLength = 32'h0000_2000;

  localparam int unsigned RomWords = RomLength >> mem_bus_pkg::WordOffset;
  localparam int unsigned SpmWords = SpmLength >> mem_bus_pkg::WordOffset;

  // Word index sized for the larger region
  localparam int unsigned RomIdxWidth = $clog2(RomWords);
  localparam int unsigned SpmIdxWidth = $clog2(SpmWords);

  typedef logic [SpmIdxWidth-1:0] word_idx_t;

  // --------------------
  // Rule table
  // --------------------
  // End address is exclusive
  typedef struct packed {
    target_e            idx;
    mem_bus_pkg::addr_t start_addr;
    mem_bus_pkg::addr_t end_addr;
  } rule_t;

  localparam rule_t AddrMap [NumTargets] = '{
    '{idx: TgtRom, start_addr: RomBase, end_addr: RomBase + RomLength},
    '{idx: TgtSpm, start_addr: SpmBase, end_addr: SpmBase + SpmLength}
  };

endpackage

`default_nettype wire

// File: rtl/soc_mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module soc_mem_subsystem (
  input  wire logic               clk_i,
  input  wire logic               ndmreset_n,
  input  wire logic               req_i,
  input  wire logic               we_i,
  input  wire mem_bus_pkg::addr_t addr_i,
  input  wire mem_bus_pkg::strb_t be_i,
  input  wire mem_bus_pkg::data_t wdata_i,
  output logic                    rsp_valid_o,
  output mem_bus_pkg::data_t      rsp_rdata_o,
  output logic                    rsp_err_o
);

  logic              rom_valid;
  mem_bus_pkg::rsp_t rom_rsp;
  logic              spm_valid;
  mem_bus_pkg::rsp_t spm_rsp;
  logic              dec_err;

  mem_req_if rom_req ();
  mem_req_if spm_req ();

  // --------------------
  // Decode
  // --------------------
  region_decoder i_region_decoder (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .req_i      ( req_i      ),
    .we_i       ( we_i       ),
    .addr_i     ( addr_i     ),
    .be_i       ( be_i       ),
    .wdata_i    ( wdata_i    ),
    .rom_o      ( rom_req    ),
    .spm_o      ( spm_req    ),
    .dec_err_o  ( dec_err    )
  );

  // --------------------
  // Targets
  // --------------------
  boot_rom i_boot_rom (
    .clk_i       ( clk_i      ),
    .ndmreset_n  ( ndmreset_n ),
    .req_i       ( rom_req    ),
    .rsp_valid_o ( rom_valid  ),
    .rsp_o       ( rom_rsp    )
  );

  l2_spm i_l2_spm (
    .clk_i       ( clk_i      ),
    .ndmreset_n  ( ndmreset_n ),
    .req_i       ( spm_req    ),
    .rsp_valid_o ( spm_valid  ),
    .rsp_o       ( spm_rsp    )
  );

  rsp_merge i_rsp_merge (
    .rom_valid_i ( rom_valid   ),
    .rom_rsp_i   ( rom_rsp     ),
    .spm_valid_i ( spm_valid   ),
    .spm_rsp_i   ( spm_rsp     ),
    .dec_err_i   ( dec_err     ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_rdata_o ( rsp_rdata_o ),
    .rsp_err_o   ( rsp_err_o   )
  );

endmodule

`default_nettype wire

// File: tests/rsp_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rsp_checker (
  input  wire logic               clk_i,
  input  wire logic               ndmreset_n,
  input  wire logic               req_i,
  input  wire logic               we_i,
  input  wire mem_bus_pkg::addr_t addr_i,
  input  wire mem_bus_pkg::strb_t be_i,
  input  wire mem_bus_pkg::data_t wdata_i,
  input  wire logic               exp_use_i,
  input  wire mem_bus_pkg::data_t exp_rdata_i,
  input  wire logic               exp_err_i,
  input  wire logic               rsp_valid_i,
  input  wire mem_bus_pkg::data_t rsp_rdata_i,
  input  wire logic               rsp_err_i,
  output logic                    busy_o,
  output int unsigned             mismatch_cnt_o,
  output int unsigned             proto_cnt_o
);

  `include "boot_image.svh"

  // Scratchpad shadow, with a mask of bytes written so far
  mem_bus_pkg::data_t shadow_q [soc_map_pkg::SpmWords];
  mem_bus_pkg::strb_t known_q  [soc_map_pkg::SpmWords];

  logic               pend_q;
  mem_bus_pkg::addr_t pend_addr_q;
  mem_bus_pkg::data_t pend_rdata_q;
  mem_bus_pkg::data_t pend_mask_q;
  logic               pend_err_q;
  // Expectation from the stimulus table, if the request came from it
  logic               pend_use_q;
  mem_bus_pkg::data_t pend_tbl_rdata_q;
  logic               pend_tbl_err_q;

  assign busy_o = pend_q;

  // Inputs and outputs are both stable at the falling edge
  always @(negedge clk_i) begin : p_check
    mem_bus_pkg::addr_t                  rom_off;
    mem_bus_pkg::addr_t                  spm_off;
    logic [soc_map_pkg::SpmIdxWidth-1:0] spm_idx;
    mem_bus_pkg::data_t                  exp_rdata;
    mem_bus_pkg::data_t                  exp_mask;
    logic                                exp_err;
    int unsigned                         errs;
    if (!ndmreset_n) begin
      pend_q         <= 1'b0;
      pend_use_q     <= 1'b0;
      mismatch_cnt_o <= 0;
      proto_cnt_o    <= 0;
      known_q = '{default: '0};
    end else begin
      // --------------------
      // Response of the previous request
      // --------------------
      if (pend_q && !rsp_valid_i) begin
        $display("Missing response at time %0t for request to 0x%08h", $time, pend_addr_q);
        proto_cnt_o <= proto_cnt_o + 1;
      end else if (!pend_q && (rsp_valid_i || rsp_err_i)) begin
        $display("Unexpected response at time %0t with no request outstanding", $time);
        proto_cnt_o <= proto_cnt_o + 1;
      end else if (pend_q) begin
        errs = 0;
        if (((rsp_rdata_i & pend_mask_q) !== (pend_rdata_q & pend_mask_q)) ||
            (rsp_err_i !== pend_err_q)) begin
          $display("mismatch at time %0t: 0x%08h got %h err %0b, model %h err %0b",
                   $time, pend_addr_q, rsp_rdata_i, rsp_err_i, pend_rdata_q, pend_err_q);
          errs++;
        end
        if (pend_use_q &&
            ((rsp_rdata_i !== pend_tbl_rdata_q) || (rsp_err_i !== pend_tbl_err_q))) begin
          $display("mismatch at time %0t: 0x%08h got %h err %0b, table %h err %0b",
                   $time, pend_addr_q, rsp_rdata_i, rsp_err_i, pend_tbl_rdata_q,
                   pend_tbl_err_q);
          errs++;
        end
        mismatch_cnt_o <= mismatch_cnt_o + errs;
      end

      // --------------------
      // Model of the current request
      // --------------------
      exp_rdata = '0;
      exp_mask  = '1;
      exp_err   = 1'b0;
      rom_off   = addr_i - soc_map_pkg::RomBase;
      spm_off   = addr_i - soc_map_pkg::SpmBase;
      spm_idx   = spm_off[mem_bus_pkg::WordOffset +: soc_map_pkg::SpmIdxWidth];
      if (req_i) begin
        if (addr_i >= soc_map_pkg::RomBase &&
            addr_i < soc_map_pkg::RomBase + soc_map_pkg::RomLength) begin
          if (we_i) begin
            exp_err = 1'b1;
          end else begin
            exp_rdata = BootImage[rom_off[mem_bus_pkg::WordOffset +: soc_map_pkg::RomIdxWidth]];
          end
        end else if (addr_i >= soc_map_pkg::SpmBase &&
                     addr_i < soc_map_pkg::SpmBase + soc_map_pkg::SpmLength) begin
          for (int b = 0; b < mem_bus_pkg::StrbWidth; b++) begin
            if (we_i && be_i[b]) begin
              shadow_q[spm_idx][8*b +: 8] = wdata_i[8*b +: 8];
              known_q[spm_idx][b] = 1'b1;
            end
            // Bytes never written are not compared
            if (!we_i) begin
              exp_mask[8*b +: 8] = {8{known_q[spm_idx][b]}};
            end
          end
          if (!we_i) begin
            exp_rdata = shadow_q[spm_idx];
          end
        end else begin
          exp_err = 1'b1;
        end
      end

      pend_q           <= req_i;
      pend_addr_q      <= addr_i;
      pend_rdata_q     <= exp_rdata;
      pend_err_q       <= exp_err;
      pend_mask_q      <= exp_mask;
      pend_use_q       <= exp_use_i;
      pend_tbl_rdata_q <= exp_rdata_i;
      pend_tbl_err_q   <= exp_err_i;
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_soc_mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_mem_subsystem;

  typedef struct packed {
    logic               we;
    mem_bus_pkg::addr_t addr;
    mem_bus_pkg::strb_t be;
    mem_bus_pkg::data_t wdata;
    mem_bus_pkg::data_t rdata;
    logic               err;
  } entry_t;

  localparam int NumEntries = 18;
  localparam int SweepLen   = 64;
  localparam int MaxCycles  = NumEntries + 2 * SweepLen + 50;

  // we, addr, be, wdata, expected rdata, expected err
  localparam entry_t Stim [NumEntries] = '{
    '{1'b0, 32'h0001_0000, 8'h00, 64'h0, 64'h0000_0517_0000_0297, 1'b0},
    '{1'b0, 32'h0001_0008, 8'h00, 64'h0, 64'h0405_0513_0102_8293, 1'b0},
    '{1'b0, 32'h0001_0080, 8'h00, 64'h0, 64'h0123_4567_89AB_CDEF, 1'b0},
    '{1'b0, 32'h0001_00F8, 8'h00, 64'h0, 64'hB007_C0DE_600D_F00D, 1'b0},
    '{1'b1, 32'h0001_0010, 8'hFF, 64'h1234_5678_9ABC_DEF0, 64'h0, 1'b1},
    '{1'b0, 32'h0001_0010, 8'h00, 64'h0, 64'hF140_2573_3420_2F73, 1'b0},
    '{1'b1, 32'h1C00_0000, 8'hFF, 64'h1122_3344_5566_7788, 64'h0, 1'b0},
    '{1'b1, 32'h1C00_0000, 8'h0F, 64'hAAAA_AAAA_BBBB_BBBB, 64'h0, 1'b0},
    '{1'b1, 32'h1C00_0000, 8'h30, 64'h0000_CCDD_0000_0000, 64'h0, 1'b0},
    '{1'b0, 32'h1C00_0000, 8'h00, 64'h0, 64'h1122_CCDD_BBBB_BBBB, 1'b0},
    '{1'b1, 32'h1C00_1FF8, 8'hFF, 64'hFEED_FACE_0BAD_BEEF, 64'h0, 1'b0},
    '{1'b1, 32'h1C00_1FF8, 8'h81, 64'h0100_0000_0000_0002, 64'h0, 1'b0},
    '{1'b0, 32'h1C00_1FF8, 8'h00, 64'h0, 64'h01ED_FACE_0BAD_BE02, 1'b0},
    '{1'b0, 32'h0001_0100, 8'h00, 64'h0, 64'h0, 1'b1},
    '{1'b0, 32'h1BFF_FFFF, 8'h00, 64'h0, 64'h0, 1'b1},
    '{1'b1, 32'h0000_0000, 8'hFF, 64'hFFFF_FFFF_FFFF_FFFF, 64'h0, 1'b1},
    '{1'b0, 32'h1C00_2000, 8'h00, 64'h0, 64'h0, 1'b1},
    '{1'b0, 32'h0000_FFF8, 8'h00, 64'h0, 64'h0, 1'b1}
  };

  logic               clk;
  logic               ndmreset_n;
  logic               req;
  logic               we;
  mem_bus_pkg::addr_t addr;
  mem_bus_pkg::strb_t be;
  mem_bus_pkg::data_t wdata;
  logic               rsp_valid;
  mem_bus_pkg::data_t rsp_rdata;
  logic               rsp_err;
  logic               exp_use;
  mem_bus_pkg::data_t exp_rdata;
  logic               exp_err;
  logic               chk_busy;
  int unsigned        mismatch_cnt;
  int unsigned        proto_cnt;
  int unsigned        cycle_cnt = 0;

  soc_mem_subsystem i_soc_mem_subsystem (
    .clk_i       ( clk        ),
    .ndmreset_n  ( ndmreset_n ),
    .req_i       ( req        ),
    .we_i        ( we         ),
    .addr_i      ( addr       ),
    .be_i        ( be         ),
    .wdata_i     ( wdata      ),
    .rsp_valid_o ( rsp_valid  ),
    .rsp_rdata_o ( rsp_rdata  ),
    .rsp_err_o   ( rsp_err    )
  );

  rsp_checker i_rsp_checker (
    .clk_i          ( clk          ),
    .ndmreset_n     ( ndmreset_n   ),
    .req_i          ( req          ),
    .we_i           ( we           ),
    .addr_i         ( addr         ),
    .be_i           ( be           ),
    .wdata_i        ( wdata        ),
    .exp_use_i      ( exp_use      ),
    .exp_rdata_i    ( exp_rdata    ),
    .exp_err_i      ( exp_err      ),
    .rsp_valid_i    ( rsp_valid    ),
    .rsp_rdata_i    ( rsp_rdata    ),
    .rsp_err_i      ( rsp_err      ),
    .busy_o         ( chk_busy     ),
    .mismatch_cnt_o ( mismatch_cnt ),
    .proto_cnt_o    ( proto_cnt    )
  );

  initial begin : p_clk
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin : p_timeout
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MaxCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // One request per cycle, table entries carry their own expectation
  task automatic issue_request(input logic r_we, input mem_bus_pkg::addr_t r_addr,
                               input mem_bus_pkg::strb_t r_be,
                               input mem_bus_pkg::data_t r_wdata, input logic r_use,
                               input mem_bus_pkg::data_t r_rdata, input logic r_err);
    @(posedge clk);
    #1;
    req       = 1'b1;
    we        = r_we;
    addr      = r_addr;
    be        = r_be;
    wdata     = r_wdata;
    exp_use   = r_use;
    exp_rdata = r_rdata;
    exp_err   = r_err;
  endtask

  task automatic go_idle();
    @(posedge clk);
    #1;
    req     = 1'b0;
    we      = 1'b0;
    exp_use = 1'b0;
  endtask

  initial begin : p_main
    logic [31:0]        rnd;
    mem_bus_pkg::addr_t s_addr;
    mem_bus_pkg::data_t s_data;
    ndmreset_n = 1'b0;
    req        = 1'b0;
    we         = 1'b0;
    addr       = '0;
    be         = '0;
    wdata      = '0;
    exp_use    = 1'b0;
    exp_rdata  = '0;
    exp_err    = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    ndmreset_n = 1'b1;
    // Idle cycles, outputs must stay low
    repeat (4) @(posedge clk);

    for (int i = 0; i < NumEntries; i++) begin
      issue_request(Stim[i].we, Stim[i].addr, Stim[i].be, Stim[i].wdata, 1'b1,
                    Stim[i].rdata, Stim[i].err);
    end

    // --------------------
    // Random scratchpad sweep
    // --------------------
    rnd = 32'd96;
    for (int i = 0; i < SweepLen; i++) begin
      rnd = xorshift32(rnd);
      s_addr = soc_map_pkg::SpmBase | {23'b0, rnd[5:0], 3'b000};
      rnd = xorshift32(rnd);
      s_data[63:32] = rnd;
      rnd = xorshift32(rnd);
      s_data[31:0] = rnd;
      issue_request(1'b1, s_addr, rnd[15:8], s_data, 1'b0, '0, 1'b0);
      issue_request(1'b0, s_addr, '0, '0, 1'b0, '0, 1'b0);
    end
    go_idle();

    while (chk_busy) begin
      @(posedge clk);
    end
    $display("Mismatches: %0d, response errors: %0d", mismatch_cnt, proto_cnt);
    if (mismatch_cnt == 0 && proto_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire
